// ==== src/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // Branch bus from decode, describes the instruction sitting in decode
    typedef struct packed {
        logic        bd;        // Instruction in decode is a branch
        logic        stall;     // Branch not resolvable yet
        logic        taken;
        logic [31:0] target;
    } br_bus_t;

    // One instruction handed to decode
    typedef struct packed {
        logic        ex;
        logic [4:0]  exc_code;
        logic        bd;        // Sits in a delay slot
        logic [31:0] inst;
        logic [31:0] pc;
    } fs_to_ds_t;

    // Fetch address as the cache splits it
    typedef struct packed {
        logic [19:0] tag;
        logic [7:0]  index;
        logic [3:0]  offset;
    } icache_req_t;

    // AXI4-Lite read address and read data channels
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  prot;
    } axil_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axil_r_t;

    localparam logic [4:0]  EXC_ADEL      = 5'd4;
    localparam logic [4:0]  EXC_IBE       = 5'd6;
    localparam logic [4:0]  EXC_NONE      = 5'h1f;   // No exception

    localparam logic [31:0] RESET_PC      = 32'hbfbffffc;  // First fetch lands on bfc00000
    localparam logic [31:0] EXC_VECTOR    = 32'hbfc00380;
    localparam logic [31:0] REFILL_VECTOR = 32'hbfc00200;

    localparam logic [2:0]  AXI_PROT_INST = 3'b101;  // Instruction, privileged
    localparam logic [1:0]  AXI_RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// ==== src/cache_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

// Single write port, single registered read port
module cache_ram #(
    parameter int  DEPTH   = 256,
    parameter type entry_t = logic [31:0]
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    input  entry_t                   wdata,
    output entry_t                   rdata
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];    // Old contents on a same-address write
    end

endmodule

`default_nettype wire

// ==== src/axil_line_reader.sv ====
`timescale 1ns/10ps
`default_nettype none

module axil_line_reader #(
    parameter int LINE_WORDS = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                fill_start,
    input  logic [31:0]         fill_addr,
    output logic                fill_word_valid,
    output logic [31:0]         fill_word,
    output logic                fill_err,
    output logic                fill_done,
    output fetch_pkg::axil_ar_t m_ar,
    output logic                m_arvalid,
    input  logic                m_arready,
    input  fetch_pkg::axil_r_t  m_r,
    input  logic                m_rvalid,
    output logic                m_rready
);
    import fetch_pkg::*;

    localparam int CNT_BITS = $clog2(LINE_WORDS);

    typedef enum logic [1:0] {S_IDLE, S_ADDR, S_DATA} state_t;

    state_t              state;
    logic [CNT_BITS-1:0] word_cnt;     // Word of the line being read
    logic [31:0]         line_base;
    logic                last_beat;

    assign last_beat = (word_cnt == CNT_BITS'(LINE_WORDS - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_IDLE;
            word_cnt  <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= fill_word_valid & last_beat;   // One cycle after the last word
            case (state)
                S_IDLE: begin
                    if (fill_start) begin
                        state    <= S_ADDR;
                        word_cnt <= '0;
                    end
                end
                S_ADDR: begin
                    if (m_arready) state <= S_DATA;  // Address held until taken
                end
                S_DATA: begin
                    if (m_rvalid) begin
                        if (last_beat) begin
                            state <= S_IDLE;
                        end else begin
                            state    <= S_ADDR;
                            word_cnt <= word_cnt + 1'b1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && fill_start) line_base <= fill_addr;
    end

    // One read at a time, ascending word addresses
    assign m_arvalid = (state == S_ADDR);
    assign m_ar      = '{addr: line_base + 32'({word_cnt, 2'b00}), prot: AXI_PROT_INST};
    assign m_rready  = (state == S_DATA);

    assign fill_word_valid = (state == S_DATA) & m_rvalid;
    assign fill_word       = m_r.data;
    assign fill_err        = fill_word_valid & (m_r.resp != AXI_RESP_OKAY);  // SLVERR or DECERR

endmodule

`default_nettype wire

// ==== src/icache.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache #(
    parameter int INDEX_BITS = 8,
    parameter int LINE_WORDS = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inst_valid,
    input  fetch_pkg::icache_req_t inst_req,
    output logic                   inst_addr_ok,
    output logic                   inst_data_ok,
    output logic                   inst_err,
    output logic [31:0]            inst_rdata,
    output logic                   fill_start,
    output logic [31:0]            fill_addr,
    input  logic                   fill_word_valid,
    input  logic [31:0]            fill_word,
    input  logic                   fill_err,
    input  logic                   fill_done
);

    localparam int DEPTH     = 1 << INDEX_BITS;
    localparam int WORD_BITS = $clog2(LINE_WORDS);
    localparam int OFF_BITS  = WORD_BITS + 2;
    localparam int TAG_BITS  = 32 - INDEX_BITS - OFF_BITS;

    typedef struct packed {
        logic                valid;
        logic [TAG_BITS-1:0] tag;
    } tag_entry_t;

    typedef logic [LINE_WORDS-1:0][31:0] line_t;

    typedef enum logic [1:0] {S_INIT, S_IDLE, S_LOOKUP, S_FILL} state_t;

    state_t                state;
    logic [INDEX_BITS-1:0] init_idx;    // Valid-bit clearing walk
    logic [31:0]           req_addr;
    logic [INDEX_BITS-1:0] rd_index;
    logic [31:0]           req_q;       // Request under lookup or refill
    logic [TAG_BITS-1:0]   q_tag;
    logic [INDEX_BITS-1:0] q_index;
    logic [WORD_BITS-1:0]  q_word;
    line_t                 line_buf;    // Words gathered during refill
    logic                  line_err;
    logic                  hit;
    logic                  tag_we;
    logic [INDEX_BITS-1:0] tag_waddr;
    tag_entry_t            tag_wdata;
    tag_entry_t            tag_rdata;
    logic                  data_we;
    line_t                 data_rdata;

    assign req_addr = inst_req;
    assign rd_index = req_addr[OFF_BITS +: INDEX_BITS];
    assign q_tag    = req_q[31 -: TAG_BITS];
    assign q_index  = req_q[OFF_BITS +: INDEX_BITS];
    assign q_word   = req_q[2 +: WORD_BITS];

    assign hit = tag_rdata.valid && (tag_rdata.tag == q_tag);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_INIT;
            init_idx <= '0;
            line_err <= 1'b0;
        end else begin
            case (state)
                S_INIT: begin
                    init_idx <= init_idx + 1'b1;
                    if (init_idx == INDEX_BITS'(DEPTH - 1)) state <= S_IDLE;
                end
                S_IDLE: begin
                    if (inst_valid) state <= S_LOOKUP;
                end
                S_LOOKUP: begin
                    line_err <= 1'b0;
                    state    <= hit ? S_IDLE : S_FILL;
                end
                S_FILL: begin
                    if (fill_word_valid) line_err <= line_err | fill_err;
                    if (fill_done) state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && inst_valid) req_q <= req_addr;
        if (fill_word_valid) line_buf <= {fill_word, line_buf[LINE_WORDS-1:1]};  // First word ends at 0
    end

    // Tag writes come from the reset walk or the end of a refill
    assign tag_we    = (state == S_INIT) | data_we;
    assign tag_waddr = (state == S_INIT) ? init_idx : q_index;
    assign tag_wdata = (state == S_INIT) ? '0 : '{valid: ~line_err, tag: q_tag};  // Bad line stays invalid
    assign data_we   = (state == S_FILL) & fill_done;

    cache_ram #(
        .DEPTH   (DEPTH),
        .entry_t (tag_entry_t)
    ) tag_ram (
        .clk   (clk),
        .we    (tag_we),
        .waddr (tag_waddr),
        .raddr (rd_index),
        .wdata (tag_wdata),
        .rdata (tag_rdata)
    );

    cache_ram #(
        .DEPTH   (DEPTH),
        .entry_t (line_t)
    ) data_ram (
        .clk   (clk),
        .we    (data_we),
        .waddr (q_index),
        .raddr (rd_index),
        .wdata (line_buf),
        .rdata (data_rdata)
    );

    assign inst_addr_ok = (state == S_IDLE);
    assign inst_data_ok = ((state == S_LOOKUP) & hit) | data_we;
    assign inst_rdata   = (state == S_FILL) ? line_buf[q_word] : data_rdata[q_word];
    assign inst_err     = (state == S_FILL) & line_err;

    assign fill_start = (state == S_LOOKUP) & ~hit;
    assign fill_addr  = {req_q[31:OFF_BITS], {OFF_BITS{1'b0}}};  // Line base

endmodule

`default_nettype wire

// ==== src/if_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module if_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ds_allowin,
    input  fetch_pkg::br_bus_t     br_bus,
    input  logic                   flush,
    input  logic                   flush_refill,
    input  logic                   eret,
    input  logic [31:0]            epc,
    output logic                   fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_t   fs_to_ds_bus,
    output logic                   inst_valid,
    output fetch_pkg::icache_req_t inst_req,
    input  logic                   inst_addr_ok,
    input  logic                   inst_data_ok,
    input  logic                   inst_err,
    input  logic [31:0]            inst_rdata
);
    import fetch_pkg::*;

    logic [31:0] pc;           // Last selected PC
    logic        start_q;      // First cycle out of reset
    logic        req_pend;     // Waiting for addr_ok
    logic        busy;         // Accepted by the cache, answer outstanding
    logic        discard;      // Outstanding answer overtaken by a redirect
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        accept;
    logic        select;
    logic [31:0] nextpc;
    logic        misaligned;
    logic        slot_ex;
    logic [4:0]  slot_code;
    logic [31:0] slot_inst;
    logic [31:0] slot_pc;

    // eret wins over refill flush, refill flush over flush
    assign redirect    = eret | flush_refill | flush;
    assign redirect_pc = eret ? epc : (flush_refill ? REFILL_VECTOR : EXC_VECTOR);

    // A stalled branch in decode holds the delay slot here
    assign accept = fs_to_ds_valid & ds_allowin & ~br_bus.stall;
    assign select = redirect | accept | start_q;

    // br_bus at accept describes the instruction before the slot being taken
    assign nextpc = redirect ? redirect_pc :
                    (accept & br_bus.taken) ? br_bus.target :
                    pc + 32'd4;
    assign misaligned = (nextpc[1:0] != 2'b00);   // AdEL, no cache access

    always_ff @(posedge clk) begin
        if (reset) begin
            pc             <= RESET_PC;
            start_q        <= 1'b1;
            req_pend       <= 1'b0;
            busy           <= 1'b0;
            discard        <= 1'b0;
            fs_to_ds_valid <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (select) pc <= nextpc;

            if (select) begin
                req_pend <= ~misaligned;
            end else if (inst_addr_ok) begin
                req_pend <= 1'b0;
            end

            if (inst_valid & inst_addr_ok) begin
                busy <= 1'b1;
            end else if (inst_data_ok) begin
                busy <= 1'b0;
            end

            // Answer still to come for a dropped path
            if (redirect & ((busy & ~inst_data_ok) | (inst_valid & inst_addr_ok))) begin
                discard <= 1'b1;
            end else if (inst_data_ok) begin
                discard <= 1'b0;
            end

            if (select) begin
                fs_to_ds_valid <= misaligned;   // Slot dropped or taken, AdEL goes straight in
            end else if (inst_data_ok & ~discard) begin
                fs_to_ds_valid <= 1'b1;
            end
        end
    end

    // Decode register payload
    always_ff @(posedge clk) begin
        if (select) begin
            slot_ex   <= 1'b1;
            slot_code <= EXC_ADEL;
            slot_inst <= '0;
            slot_pc   <= nextpc;
        end else if (inst_data_ok & ~discard) begin
            slot_ex   <= inst_err;
            slot_code <= inst_err ? EXC_IBE : EXC_NONE;
            slot_inst <= inst_rdata;
            slot_pc   <= pc;
        end
    end

    assign inst_valid = req_pend;
    assign inst_req   = icache_req_t'(pc);

    // Branch in decode marks the slot instruction
    assign fs_to_ds_bus = '{ex: slot_ex, exc_code: slot_code, bd: br_bus.bd,
                            inst: slot_inst, pc: slot_pc};

endmodule

`default_nettype wire

// ==== src/fetch_frontend.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend #(
    parameter int INDEX_BITS = 8,
    parameter int LINE_WORDS = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ds_allowin,
    input  fetch_pkg::br_bus_t   br_bus,
    input  logic                 flush,
    input  logic                 flush_refill,
    input  logic                 eret,
    input  logic [31:0]          epc,
    output logic                 fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_t fs_to_ds_bus,
    output fetch_pkg::axil_ar_t  m_ar,
    output logic                 m_arvalid,
    input  logic                 m_arready,
    input  fetch_pkg::axil_r_t   m_r,
    input  logic                 m_rvalid,
    output logic                 m_rready
);
    import fetch_pkg::*;

    // Fetch stage to cache
    logic        inst_valid;
    icache_req_t inst_req;
    logic        inst_addr_ok;
    logic        inst_data_ok;
    logic        inst_err;
    logic [31:0] inst_rdata;

    // Cache to refill master
    logic        fill_start;
    logic [31:0] fill_addr;
    logic        fill_word_valid;
    logic [31:0] fill_word;
    logic        fill_err;
    logic        fill_done;

    if_stage u_if_stage (
        .clk            (clk),
        .reset          (reset),
        .ds_allowin     (ds_allowin),
        .br_bus         (br_bus),
        .flush          (flush),
        .flush_refill   (flush_refill),
        .eret           (eret),
        .epc            (epc),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .inst_valid     (inst_valid),
        .inst_req       (inst_req),
        .inst_addr_ok   (inst_addr_ok),
        .inst_data_ok   (inst_data_ok),
        .inst_err       (inst_err),
        .inst_rdata     (inst_rdata)
    );

    icache #(
        .INDEX_BITS (INDEX_BITS),
        .LINE_WORDS (LINE_WORDS)
    ) u_icache (
        .clk             (clk),
        .reset           (reset),
        .inst_valid      (inst_valid),
        .inst_req        (inst_req),
        .inst_addr_ok    (inst_addr_ok),
        .inst_data_ok    (inst_data_ok),
        .inst_err        (inst_err),
        .inst_rdata      (inst_rdata),
        .fill_start      (fill_start),
        .fill_addr       (fill_addr),
        .fill_word_valid (fill_word_valid),
        .fill_word       (fill_word),
        .fill_err        (fill_err),
        .fill_done       (fill_done)
    );

    axil_line_reader #(
        .LINE_WORDS (LINE_WORDS)
    ) u_line_reader (
        .clk             (clk),
        .reset           (reset),
        .fill_start      (fill_start),
        .fill_addr       (fill_addr),
        .fill_word_valid (fill_word_valid),
        .fill_word       (fill_word),
        .fill_err        (fill_err),
        .fill_done       (fill_done),
        .m_ar            (m_ar),
        .m_arvalid       (m_arvalid),
        .m_arready       (m_arready),
        .m_r             (m_r),
        .m_rvalid        (m_rvalid),
        .m_rready        (m_rready)
    );

endmodule

`default_nettype wire

// ==== tests/fetch_frontend_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend_chk (
    input logic                 clk,
    input logic                 reset,
    input logic                 ds_allowin,
    input logic                 flush,
    input logic                 flush_refill,
    input logic                 eret,
    input logic                 fs_to_ds_valid,
    input fetch_pkg::fs_to_ds_t fs_to_ds_bus,
    input logic                 inst_valid,
    input logic                 fill_start,
    input fetch_pkg::axil_ar_t  m_ar,
    input logic                 m_arvalid,
    input logic                 m_arready,
    input logic                 m_rready
);

    // AR address held until taken
    ar_hold: assert property (@(posedge clk) disable iff (reset)
        (m_arvalid && !m_arready) |=> (m_arvalid && $stable(m_ar)))
        else $error("AR request dropped or changed before arready");

    // Back-pressure keeps the decode slot frozen unless a redirect drops it
    slot_hold: assert property (@(posedge clk) disable iff (reset)
        (fs_to_ds_valid && !ds_allowin && !(flush || flush_refill || eret))
        |=> (fs_to_ds_valid && $stable(fs_to_ds_bus)))
        else $error("decode slot changed while decode was stalled");

    reset_quiet: assert property (@(posedge clk)
        reset |=> !(fs_to_ds_valid || inst_valid || m_arvalid || m_rready || fill_start))
        else $error("control output high right after reset");

endmodule

bind fetch_frontend fetch_frontend_chk u_chk (
    .clk            (clk),
    .reset          (reset),
    .ds_allowin     (ds_allowin),
    .flush          (flush),
    .flush_refill   (flush_refill),
    .eret           (eret),
    .fs_to_ds_valid (fs_to_ds_valid),
    .fs_to_ds_bus   (fs_to_ds_bus),
    .inst_valid     (inst_valid),
    .fill_start     (fill_start),
    .m_ar           (m_ar),
    .m_arvalid      (m_arvalid),
    .m_arready      (m_arready),
    .m_rready       (m_rready)
);

`default_nettype wire

// ==== tests/fetch_frontend_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend_tb;
    import fetch_pkg::*;

    localparam int          NUM_VECS       = 24;
    localparam int          TIMEOUT_CYCLES = NUM_VECS * 40 + 200;
    localparam logic [31:0] MEM_XOR        = 32'h5a5a5a5a;   // Memory word = address ^ this
    localparam logic [19:0] ERR_PAGE       = 20'hbfc0f;      // SLVERR page

    // Decode-side actions in the vector file
    localparam logic [3:0] ACT_TAKEN     = 4'd1;
    localparam logic [3:0] ACT_STALL     = 4'd2;
    localparam logic [3:0] ACT_NOT_TAKEN = 4'd3;
    localparam logic [3:0] ACT_FLUSH     = 4'd4;
    localparam logic [3:0] ACT_REFILL    = 4'd5;
    localparam logic [3:0] ACT_ERET      = 4'd6;
    localparam logic [3:0] ACT_HOLD      = 4'd7;

    logic        clk;
    logic        reset;
    logic        ds_allowin;
    br_bus_t     br_bus;
    logic        flush;
    logic        flush_refill;
    logic        eret;
    logic [31:0] epc;
    logic        fs_to_ds_valid;
    fs_to_ds_t   fs_to_ds_bus;
    axil_ar_t    m_ar;
    logic        m_arvalid;
    logic        m_arready;
    axil_r_t     m_r;
    logic        m_rvalid;
    logic        m_rready;

    logic [91:0] vec_mem [NUM_VECS];   // pc, ex, code, bd, action, count, operand
    int          vec_idx;
    int          stall_left;
    int          hold_left;
    int          cycle_cnt;
    logic        timed_out;
    int          mismatch_cnt;
    int          fail_cnt;

    // AXI memory model state
    logic [15:0] lfsr_state;
    logic        ar_seen;
    int          ar_left;
    logic        r_pend;
    int          r_left;
    logic [31:0] rd_addr;

    int          fills [logic [31:0]];      // Line reads per line base
    bit          touched [logic [31:0]];    // Lines of good deliveries
    int          err_reads [logic [31:0]];  // IBE deliveries per line

    fetch_frontend UUT (
        .clk            (clk),
        .reset          (reset),
        .ds_allowin     (ds_allowin),
        .br_bus         (br_bus),
        .flush          (flush),
        .flush_refill   (flush_refill),
        .eret           (eret),
        .epc            (epc),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .m_ar           (m_ar),
        .m_arvalid      (m_arvalid),
        .m_arready      (m_arready),
        .m_r            (m_r),
        .m_rvalid       (m_rvalid),
        .m_rready       (m_rready)
    );

    always #5 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);   // Galois, taps 16 14 13 11
    endfunction

    // 0..3 cycles, one LFSR step per bit
    function automatic int draw_delay();
        int d;
        d = 0;
        repeat (2) begin
            lfsr_state = lfsr_next(lfsr_state);
            d = (d << 1) | lfsr_state[0];
        end
        return d;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            mismatch_cnt++;
            $display("mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_delivery(input logic [91:0] v, input int n);
        logic [31:0] pc;
        logic        ex;
        logic [4:0]  code;
        logic [31:0] line;
        pc   = v[91:60];
        ex   = v[56];
        code = v[52:48];
        line = {pc[31:4], 4'h0};
        check_value($sformatf("vector %0d pc", n), pc, fs_to_ds_bus.pc);
        check_value($sformatf("vector %0d ex", n), 32'(ex), 32'(fs_to_ds_bus.ex));
        check_value($sformatf("vector %0d exc_code", n), 32'(code), 32'(fs_to_ds_bus.exc_code));
        check_value($sformatf("vector %0d bd", n), 32'(v[44]), 32'(fs_to_ds_bus.bd));
        if (!ex) begin
            check_value($sformatf("vector %0d inst", n), pc ^ MEM_XOR, fs_to_ds_bus.inst);
            touched[line] = 1'b1;
        end else if (code == EXC_ADEL) begin
            check_value($sformatf("vector %0d inst", n), 32'h0, fs_to_ds_bus.inst);
        end else if (err_reads.exists(line)) begin
            err_reads[line] += 1;
        end else begin
            err_reads[line] = 1;
        end
    endtask

    // What decode does once it has taken this instruction
    task automatic apply_action(input logic [91:0] v);
        logic [3:0]  act;
        logic [31:0] opnd;
        act  = v[43:40];
        opnd = v[31:0];
        br_bus <= '0;
        case (act)
            ACT_TAKEN:     br_bus <= '{bd: 1'b1, stall: 1'b0, taken: 1'b1, target: opnd};
            ACT_NOT_TAKEN: br_bus <= '{bd: 1'b1, stall: 1'b0, taken: 1'b0, target: 32'h0};
            ACT_STALL: begin
                br_bus     <= '{bd: 1'b1, stall: 1'b1, taken: 1'b1, target: opnd};
                stall_left <= v[39:32];
            end
            ACT_FLUSH:  flush <= 1'b1;
            ACT_REFILL: flush_refill <= 1'b1;
            ACT_ERET: begin
                eret <= 1'b1;
                epc  <= opnd;
            end
            ACT_HOLD: begin
                ds_allowin <= 1'b0;
                hold_left  <= v[39:32];
            end
            default: ;
        endcase
    endtask

    task automatic check_line_fills();
        foreach (touched[l]) begin
            check_value($sformatf("reads of line %h", l), 32'd1,
                        fills.exists(l) ? 32'(fills[l]) : 32'd0);
        end
        foreach (err_reads[l]) begin
            if (!fills.exists(l) || fills[l] < err_reads[l]) begin
                fail_cnt++;
                $display("error line %h was not read again for each IBE delivery", l);
            end
        end
        foreach (fills[l]) begin
            if (!touched.exists(l) && !err_reads.exists(l)) begin
                fail_cnt++;
                $display("line %h was read but nothing from it was delivered", l);
            end
        end
    endtask

    // Decode side, sampled values are from before the edge
    always @(posedge clk) begin
        if (!reset) begin
            flush        <= 1'b0;   // Redirects are single-cycle pulses
            flush_refill <= 1'b0;
            eret         <= 1'b0;
            if (stall_left != 0) begin
                stall_left <= stall_left - 1;
                if (stall_left == 1) br_bus.stall <= 1'b0;
            end
            if (hold_left != 0) begin
                hold_left <= hold_left - 1;
                if (hold_left == 1) ds_allowin <= 1'b1;
            end
            // Nothing is taken while a redirect is on the bus
            if (fs_to_ds_valid && ds_allowin && !br_bus.stall && !(flush || flush_refill || eret)
                && vec_idx < NUM_VECS) begin
                check_delivery(vec_mem[vec_idx], vec_idx);
                apply_action(vec_mem[vec_idx]);
                vec_idx <= vec_idx + 1;
            end
        end
    end

    // AXI4-Lite read slave with random ready and valid delays
    always @(posedge clk) begin
        if (reset) begin
            m_arready <= 1'b0;
            m_rvalid  <= 1'b0;
            ar_seen   <= 1'b0;
            r_pend    <= 1'b0;
        end else begin
            if (m_arvalid && m_arready) begin
                m_arready <= 1'b0;
                ar_seen   <= 1'b0;
                rd_addr   <= m_ar.addr;
                r_pend    <= 1'b1;
                r_left    <= draw_delay();
                if (m_ar.addr[3:0] == 4'h0) begin   // First word marks one line read
                    if (fills.exists(m_ar.addr)) fills[m_ar.addr] += 1;
                    else fills[m_ar.addr] = 1;
                end
            end else if (m_arvalid) begin
                if (!ar_seen) begin
                    ar_seen <= 1'b1;
                    ar_left <= draw_delay();
                end else if (ar_left == 0) begin
                    m_arready <= 1'b1;
                end else begin
                    ar_left <= ar_left - 1;
                end
            end
            if (m_rvalid && m_rready) begin
                m_rvalid <= 1'b0;
                r_pend   <= 1'b0;
            end else if (r_pend && !m_rvalid) begin
                if (r_left == 0) begin
                    m_rvalid <= 1'b1;
                    m_r      <= '{data: rd_addr ^ MEM_XOR,
                                  resp: (rd_addr[31:12] == ERR_PAGE) ? 2'b10 : 2'b00};
                end else begin
                    r_left <= r_left - 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && !timed_out) begin
            cycle_cnt <= cycle_cnt + 1;
            if (cycle_cnt >= TIMEOUT_CYCLES) timed_out <= 1'b1;
        end
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        ds_allowin   = 1'b1;
        br_bus       = '0;
        flush        = 1'b0;
        flush_refill = 1'b0;
        eret         = 1'b0;
        epc          = 32'h0;
        m_arready    = 1'b0;
        m_r          = '0;
        m_rvalid     = 1'b0;
        lfsr_state   = 16'd22274;
        vec_idx      = 0;
        stall_left   = 0;
        hold_left    = 0;
        cycle_cnt    = 0;
        timed_out    = 1'b0;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        $readmemh("tests/fetch_vectors.txt", vec_mem);
        foreach (vec_mem[i]) begin
            if ($isunknown(vec_mem[i])) begin
                fail_cnt++;
                $display("vector %0d missing or unreadable in the vector file", i);
            end
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        wait (vec_idx == NUM_VECS || timed_out);
        @(posedge clk);
        if (timed_out) begin
            fail_cnt++;
            $display("run timed out after %0d cycles, %0d of %0d vectors taken",
                     cycle_cnt, vec_idx, NUM_VECS);
        end else begin
            check_line_fills();
        end
        $display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fetch_frontend.f ====
src/fetch_pkg.sv
src/cache_ram.sv
src/axil_line_reader.sv
src/icache.sv
src/if_stage.sv
src/fetch_frontend.sv
tests/fetch_frontend_chk.sv
tests/fetch_frontend_tb.sv

// ==== tests/fetch_vectors.txt ====
// Columns: pc _ ex _ exc_code _ bd _ action _ count _ operand (one accepted instruction per line)
// Actions: 0 none, 1 taken, 2 stalled taken, 3 not taken, 4 flush, 5 refill flush, 6 eret, 7 hold
bfc00000_0_1f_0_0_00_00000000
bfc00004_0_1f_0_0_00_00000000
bfc00008_0_1f_0_7_06_00000000
bfc0000c_0_1f_0_0_00_00000000
bfc00010_0_1f_0_1_00_bfc00100
bfc00014_0_1f_1_0_00_00000000
bfc00100_0_1f_0_3_00_00000000
bfc00104_0_1f_1_0_00_00000000
bfc00108_0_1f_0_2_06_bfc00004
bfc0010c_0_1f_1_0_00_00000000
bfc00004_0_1f_0_0_00_00000000
bfc00008_0_1f_0_4_00_00000000
bfc00380_0_1f_0_0_00_00000000
bfc00384_0_1f_0_5_00_00000000
bfc00200_0_1f_0_1_00_bfc04002
bfc00204_0_1f_1_0_00_00000000
bfc04002_1_04_0_6_00_bfc00104
bfc00104_0_1f_0_1_00_bfc0f7a8
bfc00108_0_1f_1_0_00_00000000
bfc0f7a8_1_06_0_4_00_00000000
bfc00380_0_1f_0_6_00_bfc0f7a8
bfc0f7a8_1_06_0_6_00_bfc00018
bfc00018_0_1f_0_0_00_00000000
bfc0001c_0_1f_0_0_00_00000000
